// File: logic/fpu_settings.svh
// fpu settings: data widths, operation latencies and the canonical quiet nan
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// data widths
`define FPU_WORD_W  32    // operand and result width
`define FPU_FLAG_W  5     // nv dz of uf nx
`define FPU_CLASS_W 10    // one-hot fclass mask
`define FPU_CNT_W   3     // latency timer width

// latencies in rising edges, from the accepting edge to the done edge
`define FPU_LAT_CMP 3     // feq flt fle fmin fmax
`define FPU_LAT_CVT 4     // fcvt.s.w fcvt.s.wu
`define FPU_LAT_BIT 2     // sign injection, moves, fclass

// positive sign, all-ones exponent, only the quiet bit set
`define FPU_CANONICAL_NAN 32'h7fc0_0000

`endif

// File: logic/fpu_pkg.sv
// fpu package: shared vector types and the operation and sequencer enums
`include "fpu_settings.svh"

package fpu_pkg;

  // single precision operand, result or integer register value
  typedef logic [`FPU_WORD_W-1:0] word_t;

  // exception flags, msb first: nv dz of uf nx
  typedef logic [`FPU_FLAG_W-1:0] fflags_t;

  // fclass mask, bit 0 is -inf ... bit 9 is quiet nan
  typedef logic [`FPU_CLASS_W-1:0] fclass_t;

  // cycles since issue
  typedef logic [`FPU_CNT_W-1:0] cycle_t;

  typedef enum logic [3:0] {
    OP_FEQ,
    OP_FLT,
    OP_FLE,
    OP_FMIN,
    OP_FMAX,
    OP_FCVT_S_W,     // signed int to float
    OP_FCVT_S_WU,    // unsigned int to float
    OP_FSGNJ,
    OP_FSGNJN,
    OP_FSGNJX,
    OP_FMV_X_W,      // float bits to integer reg
    OP_FMV_W_X,      // integer bits to float reg
    OP_FCLASS
  } fpu_op_t;

  // issue and completion states
  typedef enum logic {
    IDLE,
    WAIT_RESULT
  } seq_state_t;

endpackage

// File: logic/fpu_sequencer.sv
// fpu sequencer: accepts a start, latches operands, waits out the latency, captures the result
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_sequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             flush,
  input  logic             expired,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::word_t   fpr_rs1,
  input  fpu_pkg::word_t   fpr_rs2,
  input  fpu_pkg::word_t   gpr_rs1,
  input  fpu_pkg::word_t   cmp_result,
  input  fpu_pkg::word_t   cvt_result,
  input  fpu_pkg::word_t   bit_result,
  input  fpu_pkg::fflags_t cmp_flags,
  input  fpu_pkg::fflags_t cvt_flags,
  output fpu_pkg::fpu_op_t op_q,
  output fpu_pkg::word_t   a_q,
  output fpu_pkg::word_t   b_q,
  output fpu_pkg::word_t   int_q,
  output logic             timer_load,
  output logic             timer_run,
  output logic             busy,
  output logic             done,
  output fpu_pkg::word_t   float_result,
  output fpu_pkg::word_t   fix_result,
  output fpu_pkg::fflags_t fflags
);
  import fpu_pkg::*;

  seq_state_t state;
  logic       accept;      // start taken on this edge
  word_t      float_sel;   // result routing from op_q
  word_t      fix_sel;
  fflags_t    flags_sel;

  // flush wins over a start in the same cycle
  assign accept     = start && (state == IDLE) && !flush;
  assign timer_load = accept;
  assign timer_run  = (state == WAIT_RESULT);
  assign busy       = (state == WAIT_RESULT);   // drops on the done edge

  // pick the unit and the destination side, the other side stays zero
  always_comb begin
    float_sel = '0;
    fix_sel   = '0;
    flags_sel = '0;
    case (op_q)
      OP_FEQ, OP_FLT, OP_FLE: begin
        fix_sel   = cmp_result;   // 0 or 1 into the integer reg
        flags_sel = cmp_flags;
      end
      OP_FMIN, OP_FMAX: begin
        float_sel = cmp_result;
        flags_sel = cmp_flags;
      end
      OP_FCVT_S_W, OP_FCVT_S_WU: begin
        float_sel = cvt_result;
        flags_sel = cvt_flags;
      end
      OP_FMV_X_W, OP_FCLASS: fix_sel = bit_result;
      default: float_sel = bit_result;   // sign injection and fmv.w.x
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= IDLE;
      op_q         <= OP_FEQ;
      done         <= 1'b0;
      float_result <= '0;
      fix_result   <= '0;
      fflags       <= '0;
    end else begin
      done <= 1'b0;                     // single cycle pulse
      if (flush) begin
        state <= IDLE;                  // abandon, no done
      end else if (accept) begin
        state <= WAIT_RESULT;
        op_q  <= op;
      end else if ((state == WAIT_RESULT) && expired) begin
        state        <= IDLE;
        done         <= 1'b1;
        float_result <= float_sel;      // held until the next done
        fix_result   <= fix_sel;
        fflags       <= flags_sel;
      end
    end
  end

  // operands only need to be valid in the accepting cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q   <= fpr_rs1;
      b_q   <= fpr_rs2;
      int_q <= gpr_rs1;
    end
  end

endmodule

// File: logic/fpu_latency_timer.sv
// latency timer: counts cycles after issue and signals when the op's fixed latency is up
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_latency_timer (
  input  logic             clk,
  input  logic             rst,
  input  logic             load,
  input  logic             run,
  input  fpu_pkg::fpu_op_t op,
  output logic             expired
);
  import fpu_pkg::*;

  cycle_t count;   // edges since the accepting edge
  cycle_t lat_q;   // latency of the op in flight
  cycle_t lat_d;

  // latency per op class
  always_comb begin
    case (op)
      OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX: lat_d = cycle_t'(`FPU_LAT_CMP);
      OP_FCVT_S_W, OP_FCVT_S_WU:                lat_d = cycle_t'(`FPU_LAT_CVT);
      default:                                  lat_d = cycle_t'(`FPU_LAT_BIT);
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
      lat_q <= '0;
    end else if (load) begin
      count <= '0;
      lat_q <= lat_d;          // same op the sequencer latches on this edge
    end else if (run) begin
      count <= count + 1'b1;
    end
  end

  // one cycle early, so the sequencer's done lands on the latency edge
  assign expired = run && (count == cycle_t'(lat_q - 1'b1));

endmodule

// File: logic/fpu_compare_unit.sv
// compare unit: two-stage feq/flt/fle/fmin/fmax with the invalid flag
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_compare_unit (
  input  logic             clk,
  input  logic             rst,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::word_t   a,
  input  fpu_pkg::word_t   b,
  output fpu_pkg::word_t   result,
  output fpu_pkg::fflags_t flags
);
  import fpu_pkg::*;

  logic    a_nan;
  logic    b_nan;
  logic    any_snan;
  logic    both_zero;
  logic    minmax;
  logic    lt;              // signed-magnitude a < b
  fpu_op_t op_s1;
  word_t   a_s1;
  word_t   b_s1;
  logic    a_nan_s1;
  logic    b_nan_s1;
  logic    snan_s1;
  logic    zero_s1;
  logic    lt_s1;
  logic    any_nan;
  logic    eq;
  word_t   res_d;
  logic    nv_d;

  // stage one: operand tests
  assign a_nan     = (&a[30:23]) & (|a[22:0]);
  assign b_nan     = (&b[30:23]) & (|b[22:0]);
  assign any_snan  = (a_nan & ~a[22]) | (b_nan & ~b[22]);   // quiet bit clear
  assign both_zero = ~(|a[30:0]) & ~(|b[30:0]);              // +0 and -0 alike
  assign minmax    = (op == OP_FMIN) || (op == OP_FMAX);

  always_comb begin
    if (a[31] != b[31]) lt = a[31];            // negative one is lower
    else if (a[31])     lt = a[30:0] > b[30:0]; // both negative, larger magnitude is lower
    else                lt = a[30:0] < b[30:0];
    if (both_zero && !minmax) lt = 1'b0;       // -0 == +0 for the compare ops
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_s1    <= OP_FEQ;
      a_nan_s1 <= 1'b0;
      b_nan_s1 <= 1'b0;
      snan_s1  <= 1'b0;
      zero_s1  <= 1'b0;
      lt_s1    <= 1'b0;
    end else begin
      op_s1    <= op;
      a_nan_s1 <= a_nan;
      b_nan_s1 <= b_nan;
      snan_s1  <= any_snan;
      zero_s1  <= both_zero;
      lt_s1    <= lt;
    end
  end

  always_ff @(posedge clk) begin
    a_s1 <= a;   // min/max pass one of these through
    b_s1 <= b;
  end

  // stage two: result select
  assign any_nan = a_nan_s1 | b_nan_s1;
  assign eq      = ~any_nan & ((a_s1 == b_s1) | zero_s1);

  always_comb begin
    res_d = '0;
    nv_d  = 1'b0;
    case (op_s1)
      OP_FEQ: begin
        res_d[0] = eq;
        nv_d     = snan_s1;        // only signaling nans are invalid here
      end
      OP_FLT: begin
        res_d[0] = ~any_nan & lt_s1;
        nv_d     = any_nan;
      end
      OP_FLE: begin
        res_d[0] = ~any_nan & (lt_s1 | eq);
        nv_d     = any_nan;
      end
      OP_FMIN, OP_FMAX: begin
        if (a_nan_s1 && b_nan_s1) res_d = `FPU_CANONICAL_NAN;
        else if (a_nan_s1)        res_d = b_s1;   // the non-nan one wins
        else if (b_nan_s1)        res_d = a_s1;
        else if (op_s1 == OP_FMIN) res_d = lt_s1 ? a_s1 : b_s1;
        else                      res_d = lt_s1 ? b_s1 : a_s1;
        nv_d = any_nan;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result <= '0;
      flags  <= '0;
    end else begin
      result <= res_d;
      flags  <= {nv_d, {(`FPU_FLAG_W-1){1'b0}}};
    end
  end

endmodule

// File: logic/fpu_int_to_float.sv
// int to float: three-stage signed/unsigned 32-bit conversion, round to nearest even
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_int_to_float (
  input  logic             clk,
  input  logic             rst,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::word_t   value,
  output fpu_pkg::word_t   result,
  output fpu_pkg::fflags_t flags
);
  import fpu_pkg::*;

  logic        neg;
  word_t       mag;
  logic        neg_s1;
  word_t       mag_s1;
  logic [4:0]  lz;          // leading zeros of mag_s1
  logic        found;
  logic        neg_s2;
  logic        zero_s2;
  logic [7:0]  exp_s2;
  word_t       norm_s2;     // leading one at bit 31
  logic        guard;
  logic        sticky;
  logic        round_up;
  logic [30:0] rounded;     // exponent and mantissa after rounding

  // stage one: sign and magnitude
  assign neg = (op == OP_FCVT_S_W) & value[31];   // unsigned input is never negative
  assign mag = neg ? (~value + 1'b1) : value;     // 0x80000000 stays 2^31

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      neg_s1 <= 1'b0;
      mag_s1 <= '0;
    end else begin
      neg_s1 <= neg;
      mag_s1 <= mag;
    end
  end

  // stage two: leading zero count and normalize
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (!found && mag_s1[i]) begin
        lz    = 5'(31 - i);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      neg_s2  <= 1'b0;
      zero_s2 <= 1'b1;
      exp_s2  <= '0;
      norm_s2 <= '0;
    end else begin
      neg_s2  <= neg_s1;
      zero_s2 <= ~(|mag_s1);
      exp_s2  <= 8'd158 - {3'b000, lz};   // bias 127 plus 31 minus shift
      norm_s2 <= mag_s1 << lz;
    end
  end

  // stage three: round to nearest even
  assign guard    = norm_s2[7];                 // first dropped bit
  assign sticky   = |norm_s2[6:0];
  assign round_up = guard & (sticky | norm_s2[8]);   // ties go to even lsb
  // mantissa overflow carries straight into the exponent field
  assign rounded  = {exp_s2, norm_s2[30:8]} + 31'(round_up);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result <= '0;
      flags  <= '0;
    end else begin
      result <= zero_s2 ? '0 : {neg_s2, rounded};
      flags  <= {{(`FPU_FLAG_W-1){1'b0}}, guard | sticky};   // nx only
    end
  end

endmodule

// File: logic/fpu_bit_ops.sv
// bit ops: one-stage sign injection, fmv in both directions and fclass
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_bit_ops (
  input  logic             clk,
  input  logic             rst,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::word_t   a,
  input  fpu_pkg::word_t   b,
  input  fpu_pkg::word_t   int_value,
  output fpu_pkg::word_t   result
);
  import fpu_pkg::*;

  logic    exp_ones;
  logic    exp_zero;
  logic    frac_zero;
  fclass_t cls;       // one-hot class of a
  word_t   res_d;

  assign exp_ones  = &a[30:23];
  assign exp_zero  = ~(|a[30:23]);
  assign frac_zero = ~(|a[22:0]);

  always_comb begin
    cls    = '0;
    cls[0] =  a[31] & exp_ones & frac_zero;       // -inf
    cls[1] =  a[31] & ~exp_ones & ~exp_zero;      // negative normal
    cls[2] =  a[31] & exp_zero & ~frac_zero;      // negative subnormal
    cls[3] =  a[31] & exp_zero & frac_zero;       // -0
    cls[4] = ~a[31] & exp_zero & frac_zero;       // +0
    cls[5] = ~a[31] & exp_zero & ~frac_zero;
    cls[6] = ~a[31] & ~exp_ones & ~exp_zero;
    cls[7] = ~a[31] & exp_ones & frac_zero;       // +inf
    cls[8] = exp_ones & ~frac_zero & ~a[22];      // signaling nan, either sign
    cls[9] = exp_ones & a[22];                    // quiet nan
  end

  always_comb begin
    case (op)
      OP_FSGNJ:   res_d = {b[31], a[30:0]};
      OP_FSGNJN:  res_d = {~b[31], a[30:0]};
      OP_FSGNJX:  res_d = {a[31] ^ b[31], a[30:0]};
      OP_FMV_X_W: res_d = a;                      // raw bits, no nan clean-up
      OP_FMV_W_X: res_d = int_value;
      OP_FCLASS:  res_d = {{(`FPU_WORD_W-`FPU_CLASS_W){1'b0}}, cls};
      default:    res_d = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) result <= '0;
    else     result <= res_d;
  end

endmodule

// File: logic/fpu_top.sv
// fpu top: sequencer, latency timer and the compare, convert and bit-op units
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  logic             flush,
  input  fpu_pkg::fpu_op_t op,
  input  fpu_pkg::word_t   fpr_rs1,
  input  fpu_pkg::word_t   fpr_rs2,
  input  fpu_pkg::word_t   gpr_rs1,
  output logic             busy,
  output logic             done,
  output fpu_pkg::word_t   float_result,
  output fpu_pkg::word_t   fix_result,
  output fpu_pkg::fflags_t fflags
);
  import fpu_pkg::*;

  fpu_op_t op_q;         // latched op, drives all units
  word_t   a_q;
  word_t   b_q;
  word_t   int_q;
  word_t   cmp_result;
  word_t   cvt_result;
  word_t   bit_result;
  fflags_t cmp_flags;
  fflags_t cvt_flags;
  logic    timer_load;
  logic    timer_run;
  logic    expired;

  fpu_sequencer seq_inst (
    .clk, .rst, .start, .flush, .expired, .op,
    .fpr_rs1, .fpr_rs2, .gpr_rs1,
    .cmp_result, .cvt_result, .bit_result, .cmp_flags, .cvt_flags,
    .op_q, .a_q, .b_q, .int_q,
    .timer_load, .timer_run, .busy, .done,
    .float_result, .fix_result, .fflags
  );

  // loads on the accepting edge, so it sees the raw op that becomes op_q
  fpu_latency_timer timer_inst (
    .clk, .rst,
    .load    (timer_load),
    .run     (timer_run),
    .op      (op),
    .expired (expired)
  );

  // free-running units, the timer decides when their output is the one we want
  fpu_compare_unit cmp_inst (
    .clk, .rst, .op(op_q), .a(a_q), .b(b_q),
    .result (cmp_result),
    .flags  (cmp_flags)
  );

  fpu_int_to_float cvt_inst (
    .clk, .rst, .op(op_q), .value(int_q),
    .result (cvt_result),
    .flags  (cvt_flags)
  );

  fpu_bit_ops bit_inst (
    .clk, .rst, .op(op_q), .a(a_q), .b(b_q), .int_value(int_q),
    .result (bit_result)
  );

endmodule

// File: bench/fpu_tb_tests.svh
// fpu directed tests and the reference models they compare against

function automatic bit is_nan(input word_t x);
  return (x[30:23] == 8'hff) && (x[22:0] != 0);
endfunction

function automatic bit is_snan(input word_t x);
  return is_nan(x) && !x[22];     // quiet bit clear
endfunction

// maps a float onto an unsigned order with -0 just below +0
function automatic word_t order_key(input word_t x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

// sign injection keeps the magnitude of a and takes the sign the op picks
function automatic word_t sign_inject_model(input fpu_op_t o, input word_t a, input word_t b);
  bit a_neg;
  bit b_neg;
  bit res_neg;
  a_neg = (a & 32'h8000_0000) != 0;
  b_neg = (b & 32'h8000_0000) != 0;
  case (o)
    OP_FSGNJN: res_neg = !b_neg;            // opposite of the sign of b
    OP_FSGNJX: res_neg = (a_neg != b_neg);  // sign of the product a*b
    default:   res_neg = b_neg;             // fsgnj copies the sign of b
  endcase
  return (a & 32'h7fff_ffff) | (res_neg ? 32'h8000_0000 : 32'h0000_0000);
endfunction

task automatic compare_model(input fpu_op_t o, input word_t a, input word_t b,
                             output word_t res, output fflags_t fl);
  bit unordered;
  bit equal;
  bit less;
  unordered = is_nan(a) || is_nan(b);
  equal     = !unordered && ((a == b) || ((a[30:0] == 0) && (b[30:0] == 0)));
  less      = !unordered && !equal && (order_key(a) < order_key(b));
  res = '0;
  fl  = '0;
  fl[`FPU_FLAG_W-1] = (o == OP_FEQ) ? (is_snan(a) || is_snan(b)) : unordered;   // nv
  case (o)
    OP_FEQ: res[0] = equal;
    OP_FLT: res[0] = less;
    OP_FLE: res[0] = less || equal;
    default: begin                 // fmin and fmax
      if (is_nan(a) && is_nan(b)) res = `FPU_CANONICAL_NAN;
      else if (is_nan(a)) res = b;
      else if (is_nan(b)) res = a;
      else if (order_key(a) < order_key(b)) res = (o == OP_FMIN) ? a : b;
      else res = (o == OP_FMIN) ? b : a;
    end
  endcase
endtask

// round to nearest even on the bits below the 24-bit significand
task automatic convert_model(input bit signed_op, input word_t v,
                             output word_t res, output fflags_t fl);
  bit    neg;
  word_t mag;
  word_t kept;
  word_t rem;
  word_t half;
  int    p;
  int    shift;
  bit [7:0] e;
  neg = signed_op && v[31];
  mag = neg ? -v : v;
  res = '0;
  fl  = '0;
  rem = '0;
  if (mag == 0) return;
  p = 31;
  while (!mag[p]) p--;             // msb position
  e = 8'(127 + p);
  if (p <= 23) begin
    kept = mag << (23 - p);        // exact
  end else begin
    shift = p - 23;
    kept  = mag >> shift;
    rem   = mag & ((32'd1 << shift) - 1);
    half  = 32'd1 << (shift - 1);
    if (rem > half || (rem == half && kept[0])) kept++;
    if (kept[24]) begin            // rounded up to the next power of two
      kept = kept >> 1;
      e++;
    end
  end
  fl[0] = (rem != 0);              // nx
  res   = {neg, e, kept[22:0]};
endtask

task automatic after_reset();
  int err0;
  err0 = errors;
  if (busy || done) begin
    errors++;
    $display("[ERROR] %0t: busy=%b done=%b after reset", $time, busy, done);
  end
  check_word("float_result after reset", float_result, '0);
  check_word("fix_result after reset", fix_result, '0);
  check_flags("fflags after reset", fflags, '0);
  report_test("after_reset", err0);
endtask

task automatic compare_and_minmax();
  // ordinary values, signed zeros, quiet and signaling nans, infinities
  word_t   a_vals [12] = '{32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 32'hbf80_0000,
                           32'hc000_0000, 32'h0000_0000, 32'h8000_0000, 32'h7fc0_0000,
                           32'h3f80_0000, 32'h7f80_0001, 32'hffc0_0000, 32'hff80_0000};
  word_t   b_vals [12] = '{32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000,
                           32'hbf80_0000, 32'h8000_0000, 32'h0000_0000, 32'h3f80_0000,
                           32'h7f80_0001, 32'h7fc0_0000, 32'h7fc0_0000, 32'h7f80_0000};
  fpu_op_t ops [5] = '{OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX};
  word_t   exp_res;
  fflags_t exp_fl;
  int      err0;
  err0 = errors;
  foreach (a_vals[i]) begin
    foreach (ops[k]) begin
      compare_model(ops[k], a_vals[i], b_vals[i], exp_res, exp_fl);
      run_and_check(ops[k], a_vals[i], b_vals[i], $urandom(), `FPU_LAT_CMP,
                    (ops[k] == OP_FMIN) || (ops[k] == OP_FMAX), exp_res, exp_fl);
    end
  end
  report_test("compare_and_minmax", err0);
endtask

task automatic int_conversion();
  // zero, one, -1, int min, int max, ties to even, carry into the exponent
  word_t   edge_vals [10] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
                              32'h7fff_ffff, 32'h0100_0001, 32'h0100_0003, 32'h0200_0006,
                              32'h7fff_ffc0, 32'h00ff_ffff};
  word_t   v;
  word_t   exp_res;
  fflags_t exp_fl;
  int      err0;
  err0 = errors;
  for (int i = 0; i < 26; i++) begin
    if (i < 10) v = edge_vals[i];
    else v = $urandom();
    convert_model(1'b1, v, exp_res, exp_fl);
    run_and_check(OP_FCVT_S_W, $urandom(), $urandom(), v, `FPU_LAT_CVT, 1'b1, exp_res, exp_fl);
    convert_model(1'b0, v, exp_res, exp_fl);
    run_and_check(OP_FCVT_S_WU, $urandom(), $urandom(), v, `FPU_LAT_CVT, 1'b1, exp_res, exp_fl);
  end
  report_test("int_conversion", err0);
endtask

task automatic sign_and_move_ops();
  // one value per class in fclass bit order
  word_t   class_vals [10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                               32'h0000_0000, 32'h0000_0001, 32'h3f80_0000, 32'h7f80_0000,
                               32'h7f80_0001, 32'h7fc0_0000};
  fpu_op_t sgnj_ops [3] = '{OP_FSGNJ, OP_FSGNJN, OP_FSGNJX};
  word_t   a;
  word_t   b;
  word_t   g;
  int      err0;
  err0 = errors;
  for (int i = 0; i < 12; i++) begin
    a = $urandom();
    b = $urandom();
    g = $urandom();
    foreach (sgnj_ops[k]) begin
      run_and_check(sgnj_ops[k], a, b, g, `FPU_LAT_BIT, 1'b1,
                    sign_inject_model(sgnj_ops[k], a, b), '0);
    end
    run_and_check(OP_FMV_X_W, a, b, g, `FPU_LAT_BIT, 1'b0, a, '0);   // float bits to gpr
    run_and_check(OP_FMV_W_X, a, b, g, `FPU_LAT_BIT, 1'b1, g, '0);
  end
  foreach (class_vals[k]) begin
    run_and_check(OP_FCLASS, class_vals[k], $urandom(), $urandom(), `FPU_LAT_BIT, 1'b0,
                  word_t'(1) << k, '0);
  end
  report_test("sign_and_move_ops", err0);
endtask

task automatic handshake_timing();
  int      err0;
  int      dones;
  int      first_done;
  word_t   fix_seen;
  fflags_t flags_seen;
  err0       = errors;
  dones      = 0;
  first_done = 0;
  fix_seen   = '0;
  flags_seen = '0;
  @(posedge clk);
  start   <= 1'b1;
  op      <= OP_FLT;
  fpr_rs1 <= 32'h3f80_0000;        // 1.0 < 2.0
  fpr_rs2 <= 32'h4000_0000;
  @(posedge clk);                  // accepting edge
  start <= 1'b0;
  for (int edges = 1; edges <= 12; edges++) begin   // bounded watch window
    @(posedge clk);
    if (edges == 1) begin          // second start while busy
      start   <= 1'b1;
      op      <= OP_FCVT_S_W;
      fpr_rs1 <= 32'h4080_0000;    // 4.0 would flip the compare if taken
      gpr_rs1 <= 32'd5;
    end else if (edges == 2) begin
      start <= 1'b0;
    end
    @(negedge clk);
    if (done) begin
      dones++;
      if (dones == 1) begin
        first_done = edges;
        fix_seen   = fix_result;
        flags_seen = fflags;
      end
    end
    if ((dones == 0 && !busy) || (dones > 0 && busy)) begin
      errors++;
      $display("[ERROR] %0t: busy=%b outside the accept-to-done window", $time, busy);
    end
  end
  if (dones == 0) begin
    errors++;
    $display("timeout: flt gave no done within 12 cycles");
  end else begin
    check_latency("flt done latency", first_done, `FPU_LAT_CMP);
    check_word("flt fix_result", fix_seen, 32'd1);
    check_flags("flt fflags", flags_seen, '0);
  end
  if (dones > 1) begin
    errors++;
    $display("unexpected done: the start issued while busy was accepted");
  end
  report_test("handshake_timing", err0);
endtask

task automatic flush_recovery();
  int      err0;
  word_t   exp_res;
  fflags_t exp_fl;
  err0 = errors;
  @(posedge clk);
  start   <= 1'b1;
  op      <= OP_FCVT_S_W;
  gpr_rs1 <= 32'h0012_3457;
  @(posedge clk);                  // conversion accepted
  start <= 1'b0;
  @(posedge clk);
  flush <= 1'b1;
  @(posedge clk);                  // sequencer back to idle here
  flush <= 1'b0;
  repeat (8) begin                 // well past where the conversion would end
    @(negedge clk);
    if (done) begin
      errors++;
      $display("unexpected done at %0t after the conversion was flushed", $time);
    end
    if (busy) begin
      errors++;
      $display("[ERROR] %0t: busy still high after flush", $time);
    end
  end
  convert_model(1'b1, 32'hffff_fff9, exp_res, exp_fl);   // -7
  run_and_check(OP_FCVT_S_W, $urandom(), $urandom(), 32'hffff_fff9, `FPU_LAT_CVT, 1'b1,
                exp_res, exp_fl);
  report_test("flush_recovery", err0);
endtask

// File: bench/fpu_tb.sv
// fpu testbench: clock, reset, dut instance, result checks and the closing summary
`timescale 1ns/1ps
`include "fpu_settings.svh"

module fpu_tb;
  import fpu_pkg::*;

  localparam int DONE_TIMEOUT = 16;   // cycles allowed between accept and done

  logic    clk;
  logic    rst;
  logic    start;
  logic    flush;
  fpu_op_t op;
  word_t   fpr_rs1;
  word_t   fpr_rs2;
  word_t   gpr_rs1;
  logic    busy;
  logic    done;
  word_t   float_result;
  word_t   fix_result;
  fflags_t fflags;

  int checks;    // compares made
  int errors;    // compares and protocol checks that failed

  fpu_top fpu_top_inst (
    .clk, .rst, .start, .flush, .op,
    .fpr_rs1, .fpr_rs2, .gpr_rs1,
    .busy, .done, .float_result, .fix_result, .fflags
  );

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input string what, input fflags_t got, input fflags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %0d edges expected %0d", $time, what, got, exp);
    end
  endtask

  // one line per finished test
  task automatic report_test(input string name, input int err0);
    if (errors == err0) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - err0);
  endtask

  // issue one op, wait for done with a timeout, then check every output
  task automatic run_and_check(input fpu_op_t o, input word_t rs1, input word_t rs2,
                               input word_t grs1, input int exp_lat, input bit float_side,
                               input word_t exp_res, input fflags_t exp_fl);
    int    lat;
    bit    seen;
    string tag;
    lat  = 0;
    seen = 1'b0;
    tag  = $sformatf("%s rs1=%h rs2=%h gpr=%h", o.name(), rs1, rs2, grs1);
    @(posedge clk);
    start   <= 1'b1;
    op      <= o;
    fpr_rs1 <= rs1;
    fpr_rs2 <= rs2;
    gpr_rs1 <= grs1;
    @(posedge clk);                   // dut accepts on this edge
    start   <= 1'b0;
    fpr_rs1 <= $urandom();            // operands are latched, scramble the bus
    fpr_rs2 <= $urandom();
    gpr_rs1 <= $urandom();
    while (!seen && lat < DONE_TIMEOUT) begin
      @(posedge clk);
      lat++;
      @(negedge clk);                 // outputs settled mid-cycle
      seen = done;
      // busy high up to the done edge, low once done shows
      if (busy == done) begin
        errors++;
        $display("[ERROR] %0t: %s busy=%b with done=%b", $time, tag, busy, done);
      end
    end
    if (!seen) begin
      errors++;
      $display("timeout: %s gave no done within %0d cycles", tag, DONE_TIMEOUT);
    end else begin
      check_latency({tag, " latency"}, lat, exp_lat);
      check_word({tag, " float_result"}, float_result, float_side ? exp_res : word_t'(0));
      check_word({tag, " fix_result"}, fix_result, float_side ? word_t'(0) : exp_res);
      check_flags({tag, " fflags"}, fflags, exp_fl);
    end
  endtask

  `include "fpu_tb_tests.svh"

  initial begin
    void'($urandom(32'h7693));        // single seed for the whole run
    checks  = 0;
    errors  = 0;
    rst     = 1'b1;
    start   = 1'b0;
    flush   = 1'b0;
    op      = OP_FEQ;
    fpr_rs1 = '0;
    fpr_rs2 = '0;
    gpr_rs1 = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    after_reset();
    compare_and_minmax();
    int_conversion();
    sign_and_move_ops();
    handshake_timing();
    flush_recovery();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
+incdir+bench
logic/fpu_pkg.sv
logic/fpu_sequencer.sv
logic/fpu_latency_timer.sv
logic/fpu_compare_unit.sv
logic/fpu_int_to_float.sv
logic/fpu_bit_ops.sv
logic/fpu_top.sv
bench/fpu_tb.sv

// File: Bender.yml
package:
  name: fpu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpu_pkg.sv
      - logic/fpu_sequencer.sv
      - logic/fpu_latency_timer.sv
      - logic/fpu_compare_unit.sv
      - logic/fpu_int_to_float.sv
      - logic/fpu_bit_ops.sv
      - logic/fpu_top.sv
  - target: simulation
    include_dirs:
      - logic
      - bench
    files:
      - bench/fpu_tb.sv
